//--- soc_defs.svh
/*
 * Peripheral subsystem constants
 * Clock rate, APB address map, register offsets and reset values
 */

`ifndef SOC_DEFS_SVH
`define SOC_DEFS_SVH

// Clock cycles per microsecond
`define CLK_MHZ 4

// ------------------------------
// Address map
`define APB_SEL_MASK 16'hc000
`define TIMER_BASE 16'h0000
`define UART_BASE 16'h4000

// ------------------------------
// Timer registers
`define TIMER_CTRL_OFS 16'h0000
`define TIMER_MTIME_OFS 16'h0008
`define TIMER_MTIMEH_OFS 16'h000c
`define TIMER_MTIMECMP_OFS 16'h0010
`define TIMER_MTIMECMPH_OFS 16'h0014
`define MTIMECMP_RESET 64'hffff_ffff_ffff_ffff

// ------------------------------
// UART registers
`define UART_DATA_OFS 16'h0000
`define UART_STAT_OFS 16'h0004
`define UART_DIV_OFS 16'h0008
`define UART_DIV_RESET 16'd8

`endif

//--- soc_pkg.sv
/*
 * Shared types for the peripheral subsystem
 * APB vectors, timer count, UART divider, byte and FSM state
 */

package soc_pkg;

	// APB bus
	typedef logic [15:0] apb_addr_t;
	typedef logic [31:0] apb_data_t;

	// Machine timer count and compare
	typedef logic [63:0] mtime_t;

	// UART
	typedef logic [15:0] uart_div_t;
	typedef logic [7:0] uart_byte_t;

	typedef enum logic [1:0] {
		IDLE,
		START,
		DATA,
		STOP
	} uart_state_e;

endpackage

//--- apb_decode.sv
/*
 * APB address decoder
 * Slave selects for timer and UART, read data return mux,
 * error response for unmapped addresses
 */

`include "soc_defs.svh"

module apb_decode import soc_pkg::*; (
	input  logic      psel,
	input  logic      penable,
	input  apb_addr_t paddr,

	output logic      timer_psel,
	output logic      uart_psel,
	input  apb_data_t timer_prdata,
	input  apb_data_t uart_prdata,

	output apb_data_t prdata,
	output logic      pslverr
);

	apb_addr_t sel_bits;
	logic      timer_hit;
	logic      uart_hit;

	// Region match on the upper address bits
	assign sel_bits  = paddr & apb_addr_t'(`APB_SEL_MASK);
	assign timer_hit = (sel_bits == apb_addr_t'(`TIMER_BASE));
	assign uart_hit  = (sel_bits == apb_addr_t'(`UART_BASE));

	assign timer_psel = psel & timer_hit;
	assign uart_psel  = psel & uart_hit;

	// Unmapped region, flagged only in the access phase
	assign pslverr = psel & penable & ~(timer_hit | uart_hit);

	// ------------------------------
	// Read data return
	always_comb begin
		if (timer_hit) begin
			prdata = timer_prdata;
		end else if (uart_hit) begin
			prdata = uart_prdata;
		end else begin
			prdata = '0;
		end
	end

endmodule

//--- us_tick_gen.sv
/*
 * Microsecond timebase
 * One-cycle tick every CLK_MHZ clock cycles
 */

`include "soc_defs.svh"

module us_tick_gen (
	input  logic clk,
	input  logic rst_n,
	output logic tick
);

	typedef logic [$clog2(`CLK_MHZ)-1:0] tick_ctr_t;

	tick_ctr_t ctr;

	// Start from the top so the first tick lands CLK_MHZ cycles after reset
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ctr  <= tick_ctr_t'(`CLK_MHZ - 1);
			tick <= 1'b0;
		end else begin
			if (ctr == '0) begin
				ctr <= tick_ctr_t'(`CLK_MHZ - 1);
			end else begin
				ctr <= ctr - 1'b1;
			end
			tick <= (ctr == '0);
		end
	end

endmodule

//--- riscv_timer.sv
/*
 * RISC-V machine timer, APB slave
 * CTRL enable, 64-bit mtime and mtimecmp as 32-bit halves,
 * debug halt freeze and registered interrupt compare
 */

`include "soc_defs.svh"

module riscv_timer import soc_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,

	input  logic      psel,
	input  logic      penable,
	input  logic      pwrite,
	input  apb_addr_t paddr,
	input  apb_data_t pwdata,
	output apb_data_t prdata,

	input  logic      tick,
	input  logic      dbg_halt,

	output logic      timer_irq
);

	apb_addr_t ofs;
	logic      wr_en;
	logic      count_en;
	logic      ctrl_en;
	mtime_t    mtime;
	mtime_t    mtimecmp;

	// Region already decoded upstream, keep the offset only
	assign ofs   = paddr & ~apb_addr_t'(`APB_SEL_MASK);
	assign wr_en = psel & penable & pwrite;

	// Counter frozen while the hart sits in debug halt
	assign count_en = tick & ctrl_en & ~dbg_halt;

	// ------------------------------
	// Registers and counting
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ctrl_en   <= 1'b1;
			mtime     <= '0;
			mtimecmp  <= `MTIMECMP_RESET;
			timer_irq <= 1'b0;
		end else begin
			if (wr_en && ofs == `TIMER_CTRL_OFS) begin
				ctrl_en <= pwdata[0];
			end

			// Software write wins over the tick increment
			if (wr_en && ofs == `TIMER_MTIME_OFS) begin
				mtime[31:0] <= pwdata;
			end else if (wr_en && ofs == `TIMER_MTIMEH_OFS) begin
				mtime[63:32] <= pwdata;
			end else if (count_en) begin
				mtime <= mtime + 64'd1;
			end

			if (wr_en && ofs == `TIMER_MTIMECMP_OFS) begin
				mtimecmp[31:0] <= pwdata;
			end
			if (wr_en && ofs == `TIMER_MTIMECMPH_OFS) begin
				mtimecmp[63:32] <= pwdata;
			end

			// Level interrupt, one cycle behind the compare
			timer_irq <= (mtime >= mtimecmp);
		end
	end

	// ------------------------------
	// Read mux
	always_comb begin
		case (ofs)
			`TIMER_CTRL_OFS:      prdata = {31'b0, ctrl_en};
			`TIMER_MTIME_OFS:     prdata = mtime[31:0];
			`TIMER_MTIMEH_OFS:    prdata = mtime[63:32];
			`TIMER_MTIMECMP_OFS:  prdata = mtimecmp[31:0];
			`TIMER_MTIMECMPH_OFS: prdata = mtimecmp[63:32];
			default:              prdata = '0;
		endcase
	end

endmodule

//--- uart_tx.sv
/*
 * Transmit-only UART, APB slave
 * DATA, STAT and DIV registers, frame FSM and bit shifter
 */

`include "soc_defs.svh"

module uart_tx import soc_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,

	input  logic      psel,
	input  logic      penable,
	input  logic      pwrite,
	input  apb_addr_t paddr,
	input  apb_data_t pwdata,
	output apb_data_t prdata,

	output logic      tx
);

	apb_addr_t   ofs;
	logic        wr_en;
	logic        busy;
	uart_state_e state;
	uart_div_t   div;
	uart_div_t   frame_div;
	uart_div_t   bit_cnt;
	logic [2:0]  bit_idx;
	uart_byte_t  shift;

	assign ofs   = paddr & ~apb_addr_t'(`APB_SEL_MASK);
	assign wr_en = psel & penable & pwrite;
	assign busy  = (state != IDLE);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			div <= `UART_DIV_RESET;
		end else if (wr_en && ofs == `UART_DIV_OFS) begin
			div <= pwdata[15:0];
		end
	end

	// ------------------------------
	// Frame FSM
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state   <= IDLE;
			tx      <= 1'b1;
			bit_cnt <= '0;
			bit_idx <= '0;
		end else begin
			case (state)
				IDLE: begin
					// Divider latched per frame, so DIV writes wait for the next one
					if (wr_en && ofs == `UART_DATA_OFS) begin
						state     <= START;
						tx        <= 1'b0;
						shift     <= pwdata[7:0];
						frame_div <= div;
						bit_cnt   <= div - 1'b1;
					end
				end
				START, DATA, STOP: begin
					if (bit_cnt != '0) begin
						bit_cnt <= bit_cnt - 1'b1;
					end else begin
						bit_cnt <= frame_div - 1'b1;
						if (state == STOP) begin
							state <= IDLE;
						end else if (state == DATA && bit_idx == 3'd7) begin
							state <= STOP;
							tx    <= 1'b1;
						end else begin
							// LSB first
							state   <= DATA;
							tx      <= shift[0];
							shift   <= shift >> 1;
							bit_idx <= (state == START) ? 3'd0 : bit_idx + 3'd1;
						end
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_comb begin
		case (ofs)
			`UART_STAT_OFS: prdata = {31'b0, busy};
			`UART_DIV_OFS:  prdata = {16'b0, div};
			default:        prdata = '0;
		endcase
	end

endmodule

//--- periph_top.sv
/*
 * APB peripheral subsystem top level
 * Decoder, microsecond tick, machine timer and UART transmitter
 */

module periph_top import soc_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,

	// APB port, zero wait states
	input  logic      psel,
	input  logic      penable,
	input  logic      pwrite,
	input  apb_addr_t paddr,
	input  apb_data_t pwdata,
	output apb_data_t prdata,
	output logic      pslverr,

	input  logic      dbg_halt,

	output logic      timer_irq,
	output logic      tx
);

	logic      timer_psel;
	logic      uart_psel;
	apb_data_t timer_prdata;
	apb_data_t uart_prdata;
	logic      tick;

	// ------------------------------
	// Bus decode
	apb_decode i_decode (
		.psel         (psel),
		.penable      (penable),
		.paddr        (paddr),
		.timer_psel   (timer_psel),
		.uart_psel    (uart_psel),
		.timer_prdata (timer_prdata),
		.uart_prdata  (uart_prdata),
		.prdata       (prdata),
		.pslverr      (pslverr)
	);

	// ------------------------------
	// Timer and its timebase
	us_tick_gen i_tick (
		.clk   (clk),
		.rst_n (rst_n),
		.tick  (tick)
	);

	riscv_timer i_timer (
		.clk       (clk),
		.rst_n     (rst_n),
		.psel      (timer_psel),
		.penable   (penable),
		.pwrite    (pwrite),
		.paddr     (paddr),
		.pwdata    (pwdata),
		.prdata    (timer_prdata),
		.tick      (tick),
		.dbg_halt  (dbg_halt),
		.timer_irq (timer_irq)
	);

	// ------------------------------
	// Serial output
	uart_tx i_uart (
		.clk     (clk),
		.rst_n   (rst_n),
		.psel    (uart_psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.prdata  (uart_prdata),
		.tx      (tx)
	);

endmodule

//--- tb_periph_top.sv
/*
 * Testbench for the APB peripheral subsystem
 * Clock and reset, APB transfer tasks, UART frame monitor,
 * typed compare tasks, stimulus table and watchdog
 */

`include "soc_defs.svh"

module tb_periph_top import soc_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD = 4;
	localparam int N_STEPS    = 36;
	// Longest step is a frame plus the idle watch at the largest divider
	localparam int MAX_DIV    = 12;
	localparam int STEP_MAX   = 20 * MAX_DIV + 16;
	localparam int TIMEOUT_NS = (N_STEPS * STEP_MAX + 10) * CLK_PERIOD;

	localparam apb_addr_t T_CTRL   = `TIMER_BASE + `TIMER_CTRL_OFS;
	localparam apb_addr_t T_MTIME  = `TIMER_BASE + `TIMER_MTIME_OFS;
	localparam apb_addr_t T_MTIMEH = `TIMER_BASE + `TIMER_MTIMEH_OFS;
	localparam apb_addr_t T_CMP    = `TIMER_BASE + `TIMER_MTIMECMP_OFS;
	localparam apb_addr_t T_CMPH   = `TIMER_BASE + `TIMER_MTIMECMPH_OFS;
	localparam apb_addr_t U_DATA   = `UART_BASE + `UART_DATA_OFS;
	localparam apb_addr_t U_STAT   = `UART_BASE + `UART_STAT_OFS;
	localparam apb_addr_t U_DIV    = `UART_BASE + `UART_DIV_OFS;

	typedef enum {OP_WRITE, OP_READ, OP_WAIT, OP_HALT, OP_IRQ, OP_SEND} op_e;

	typedef struct {
		string     name;
		op_e       op;
		apb_addr_t addr;
		apb_data_t data;
		apb_data_t exp;
		apb_data_t tol;
		logic      err;
	} step_t;

	logic      clk;
	logic      rst_n;
	logic      psel;
	logic      penable;
	logic      pwrite;
	apb_addr_t paddr;
	apb_data_t pwdata;
	apb_data_t prdata;
	logic      pslverr;
	logic      dbg_halt;
	logic      timer_irq;
	logic      tx;

	step_t      steps[N_STEPS];
	int         n_steps;
	uart_div_t  uart_div;
	uart_byte_t tx_byte;
	apb_data_t  cmp_ofs;

	periph_top i_dut (
		.clk       (clk),
		.rst_n     (rst_n),
		.psel      (psel),
		.penable   (penable),
		.pwrite    (pwrite),
		.paddr     (paddr),
		.pwdata    (pwdata),
		.prdata    (prdata),
		.pslverr   (pslverr),
		.dbg_halt  (dbg_halt),
		.timer_irq (timer_irq),
		.tx        (tx)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// ------------------------------
	// Compare tasks
	task automatic stop_on_error();
		$display("Test failures found");
		$fatal(1, "Stopping at the first mismatch");
	endtask

	task automatic check_data(input string name, input apb_data_t exp, input apb_data_t act);
		if (act !== exp) begin
			$display("ERROR %s: expected %h, actual %h", name, exp, act);
			stop_on_error();
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("ERROR %s: expected %b, actual %b", name, exp, act);
			stop_on_error();
		end
	endtask

	task automatic check_byte(input string name, input uart_byte_t exp, input uart_byte_t act);
		if (act !== exp) begin
			$display("ERROR %s: expected %h, actual %h", name, exp, act);
			stop_on_error();
		end
	endtask

	// ------------------------------
	// APB transfers, sampled mid access cycle
	task automatic apb_write(input apb_addr_t addr, input apb_data_t data, output logic err);
		@(posedge clk);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= 1'b1;
		paddr   <= addr;
		pwdata  <= data;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);
		err = pslverr;
		@(posedge clk);
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic err);
		@(posedge clk);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= 1'b0;
		paddr   <= addr;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);
		data = prdata;
		err  = pslverr;
		@(posedge clk);
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	// Frame receiver, timed from the start bit edge
	task automatic capture_byte(output uart_byte_t b);
		@(negedge tx);
		repeat (uart_div / 2) @(negedge clk);
		check_bit("uart start bit", 1'b0, tx);
		for (int i = 0; i < 8; i++) begin
			repeat (uart_div) @(negedge clk);
			b[i] = tx;
		end
		repeat (uart_div) @(negedge clk);
		check_bit("uart stop bit", 1'b1, tx);
	endtask

	task automatic add_step(input string name, input op_e op, input apb_addr_t addr,
			input apb_data_t data, input apb_data_t exp, input apb_data_t tol, input logic err);
		steps[n_steps] = '{name, op, addr, data, exp, tol, err};
		n_steps++;
	endtask

	task automatic run_step(input step_t s);
		apb_data_t  rd;
		logic       err;
		logic       seen;
		int         cnt;
		uart_byte_t rx;
		case (s.op)
			OP_WRITE: begin
				apb_write(s.addr, s.data, err);
				check_bit(s.name, s.err, err);
			end
			OP_READ: begin
				apb_read(s.addr, rd, err);
				check_bit(s.name, s.err, err);
				// Counter reads may land a tick early or late
				if (s.tol != 0 && rd >= s.exp && rd <= s.exp + s.tol) begin
					rd = s.exp;
				end
				check_data(s.name, s.exp, rd);
			end
			OP_WAIT: begin
				repeat (s.data * `CLK_MHZ) @(posedge clk);
			end
			OP_HALT: begin
				@(posedge clk);
				dbg_halt <= s.data[0];
			end
			OP_IRQ: begin
				seen = 1'b0;
				cnt  = 0;
				while (!seen && cnt < int'(s.data)) begin
					@(negedge clk);
					seen = (timer_irq === s.exp[0]);
					cnt++;
				end
				check_bit(s.name, s.exp[0], timer_irq);
			end
			OP_SEND: begin
				fork
					capture_byte(rx);
					begin
						apb_write(s.addr, s.data, err);
						check_bit(s.name, 1'b0, err);
						apb_read(U_STAT, rd, err);
						check_bit(s.name, 1'b1, rd[0]);
						// Lands mid frame and must be dropped
						apb_write(s.addr, ~s.data, err);
					end
				join
				check_byte(s.name, s.exp[7:0], rx);
				repeat (10 * uart_div) begin
					@(negedge clk);
					check_bit(s.name, 1'b1, tx);
				end
			end
			default: begin
				$display("Unknown operation in the stimulus table");
				stop_on_error();
			end
		endcase
	endtask

	// ------------------------------
	// Stimulus table
	task automatic build_table();
		n_steps = 0;
		add_step("reset ctrl", OP_READ, T_CTRL, 0, 1, 0, 1'b0);
		add_step("reset cmp lo", OP_READ, T_CMP, 0, 32'hffff_ffff, 0, 1'b0);
		add_step("reset cmp hi", OP_READ, T_CMPH, 0, 32'hffff_ffff, 0, 1'b0);
		add_step("reset div", OP_READ, U_DIV, 0, {16'b0, `UART_DIV_RESET}, 0, 1'b0);
		add_step("reset stat", OP_READ, U_STAT, 0, 0, 0, 1'b0);
		add_step("reset irq", OP_IRQ, 0, 2, 0, 0, 1'b0);
		add_step("unmapped read", OP_READ, 16'h8000, 0, 0, 0, 1'b1);
		add_step("unmapped write", OP_WRITE, 16'hc010, 32'h5a5a_5a5a, 0, 0, 1'b1);
		add_step("decode cmp write", OP_WRITE, T_CMP, 32'h1234_5678, 0, 0, 1'b0);
		add_step("decode cmp read", OP_READ, T_CMP, 0, 32'h1234_5678, 0, 1'b0);
		// Counting, ten ticks
		add_step("count clear hi", OP_WRITE, T_MTIMEH, 0, 0, 0, 1'b0);
		add_step("count clear lo", OP_WRITE, T_MTIME, 0, 0, 0, 1'b0);
		add_step("count wait", OP_WAIT, 0, 10, 0, 0, 1'b0);
		add_step("count read", OP_READ, T_MTIME, 0, 9, 2, 1'b0);
		add_step("halt set", OP_HALT, 0, 1, 0, 0, 1'b0);
		add_step("halt load", OP_WRITE, T_MTIME, 32'h100, 0, 0, 1'b0);
		add_step("halt wait", OP_WAIT, 0, 5, 0, 0, 1'b0);
		add_step("halt frozen", OP_READ, T_MTIME, 0, 32'h100, 0, 1'b0);
		add_step("halt release", OP_HALT, 0, 0, 0, 0, 1'b0);
		add_step("disable", OP_WRITE, T_CTRL, 0, 0, 0, 1'b0);
		add_step("disable load", OP_WRITE, T_MTIME, 32'h200, 0, 0, 1'b0);
		add_step("disable wait", OP_WAIT, 0, 5, 0, 0, 1'b0);
		add_step("disable frozen", OP_READ, T_MTIME, 0, 32'h200, 0, 1'b0);
		add_step("disable ctrl", OP_READ, T_CTRL, 0, 0, 0, 1'b0);
		// Interrupt armed while the counter is stopped
		add_step("irq clear mtime", OP_WRITE, T_MTIME, 0, 0, 0, 1'b0);
		add_step("irq cmp lo", OP_WRITE, T_CMP, cmp_ofs, 0, 0, 1'b0);
		add_step("irq cmp hi", OP_WRITE, T_CMPH, 0, 0, 0, 1'b0);
		add_step("irq low before", OP_IRQ, 0, 2, 0, 0, 1'b0);
		add_step("irq enable", OP_WRITE, T_CTRL, 1, 0, 0, 1'b0);
		add_step("irq rise", OP_IRQ, 0, (cmp_ofs + 1) * `CLK_MHZ + 2, 1, 0, 1'b0);
		add_step("irq cmp max", OP_WRITE, T_CMPH, 32'hffff_ffff, 0, 0, 1'b0);
		add_step("irq fall", OP_IRQ, 0, 2, 0, 0, 1'b0);
		// UART frame at a random divider
		add_step("uart div write", OP_WRITE, U_DIV, {16'b0, uart_div}, 0, 0, 1'b0);
		add_step("uart div read", OP_READ, U_DIV, 0, {16'b0, uart_div}, 0, 1'b0);
		add_step("uart frame", OP_SEND, U_DATA, {24'b0, tx_byte}, {24'b0, tx_byte}, 0, 1'b0);
		add_step("uart idle stat", OP_READ, U_STAT, 0, 0, 0, 1'b0);
	endtask

	initial begin
		#(TIMEOUT_NS);
		$display("Run timed out before the stimulus table completed");
		$display("Test failures found");
		$fatal(1, "Watchdog expired");
	end

	initial begin
		void'($urandom(34620));
		rst_n    = 1'b0;
		psel     = 1'b0;
		penable  = 1'b0;
		pwrite   = 1'b0;
		paddr    = '0;
		pwdata   = '0;
		dbg_halt = 1'b0;

		uart_div = uart_div_t'(4 + $urandom % 9);
		tx_byte  = uart_byte_t'($urandom);
		cmp_ofs  = 3 + $urandom % 5;
		build_table();

		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check_bit("reset tx idle", 1'b1, tx);

		for (int n = 0; n < n_steps; n++) begin
			run_step(steps[n]);
		end

		$display("All tests passed!");
		$finish;
	end

endmodule

//--- src.f
+incdir+.
soc_pkg.sv
apb_decode.sv
us_tick_gen.sv
riscv_timer.sv
uart_tx.sv
periph_top.sv
tb_periph_top.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_periph_top
FILELIST  = src.f
OBJ_DIR   = obj_dir
PASS_MSG  = All tests passed!

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
